// File: logic/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    localparam int NUM_LANES = 2;
    localparam int TAG_BITS  = 4;
    localparam int EXP_BITS  = 8;
    localparam int MAN_BITS  = 23;
    localparam int FRM_BITS  = 3;

    typedef enum logic [1:0] {
        OP_CLASS = 2'd0,
        OP_CMP   = 2'd1,
        OP_MISC  = 2'd2
    } fpu_op_e;

    // Compare sub-ops
    localparam logic [FRM_BITS-1:0] FRM_LE    = 3'd0;
    localparam logic [FRM_BITS-1:0] FRM_LT    = 3'd1;
    localparam logic [FRM_BITS-1:0] FRM_EQ    = 3'd2;
    // Misc sub-ops where 5 to 7 is a plain move
    localparam logic [FRM_BITS-1:0] FRM_SGNJ  = 3'd0;
    localparam logic [FRM_BITS-1:0] FRM_SGNJN = 3'd1;
    localparam logic [FRM_BITS-1:0] FRM_SGNJX = 3'd2;
    localparam logic [FRM_BITS-1:0] FRM_MIN   = 3'd3;
    localparam logic [FRM_BITS-1:0] FRM_MAX   = 3'd4;

    typedef struct packed {
        logic                sign;
        logic [EXP_BITS-1:0] exp;
        logic [MAN_BITS-1:0] man;
    } fp32_fields_t;

    typedef union packed {
        fp32_fields_t f;
        logic [31:0]  bits;
    } fp32_u;

    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_quiet;
        logic is_signaling;
    } fclass_t;

    // Bit positions in the fclass result
    localparam int CLS_NEG_INF     = 0;
    localparam int CLS_NEG_NORM    = 1;
    localparam int CLS_NEG_SUBNORM = 2;
    localparam int CLS_NEG_ZERO    = 3;
    localparam int CLS_POS_ZERO    = 4;
    localparam int CLS_POS_SUBNORM = 5;
    localparam int CLS_POS_NORM    = 6;
    localparam int CLS_POS_INF     = 7;
    localparam int CLS_SNAN        = 8;
    localparam int CLS_QNAN        = 9;

    localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        fpu_op_e               op;
        logic [FRM_BITS-1:0]   frm;
        fp32_u [NUM_LANES-1:0] a;
        fp32_u [NUM_LANES-1:0] b;
    } fpu_req_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]        tag;
        logic [NUM_LANES-1:0][31:0] result;
        logic                       has_fflags;
        logic [NUM_LANES-1:0]       nv;     // Only flag this unit raises
    } fpu_rsp_t;

endpackage

`default_nettype wire

// File: logic/fpu_class.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_class
    import fpu_pkg::*;
(
    input  wire [EXP_BITS-1:0] exp,
    input  wire [MAN_BITS-1:0] man,
    output fclass_t            cls
);

    logic exp_zero;
    logic exp_ones;
    logic man_zero;
    logic nan;

    assign exp_zero = (exp == '0);
    assign exp_ones = (exp == '1);
    assign man_zero = (man == '0);
    assign nan      = exp_ones & ~man_zero;

    assign cls.is_zero      = exp_zero & man_zero;
    assign cls.is_subnormal = exp_zero & ~man_zero;
    assign cls.is_normal    = ~exp_zero & ~exp_ones;
    assign cls.is_inf       = exp_ones & man_zero;
    assign cls.is_nan       = nan;
    assign cls.is_quiet     = nan & man[MAN_BITS-1];  // MSB of mantissa set
    assign cls.is_signaling = nan & ~man[MAN_BITS-1];

endmodule

`default_nettype wire

// File: logic/pipe_register.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_register #(
    parameter int DATAW = 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              enable,
    input  wire              valid_in,
    output logic             valid_out,
    input  wire [DATAW-1:0]  data_in,
    output logic [DATAW-1:0] data_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            data_out <= data_in;
        end
    end

    // Frozen stage keeps its item
    hold_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> $stable(data_out) && $stable(valid_out));

endmodule

`default_nettype wire

// File: logic/fpu_ncomp.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_ncomp
    import fpu_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  wire      req_valid,
    output logic     req_ready,
    input  fpu_req_t req,
    output logic     rsp_valid,
    input  wire      rsp_ready,
    output fpu_rsp_t rsp
);

    typedef struct packed {
        fpu_req_t                req;
        fclass_t [NUM_LANES-1:0] a_cls;
        fclass_t [NUM_LANES-1:0] b_cls;
        logic [NUM_LANES-1:0]    a_less;
        logic [NUM_LANES-1:0]    equal;
    } stage0_t;

    fclass_t [NUM_LANES-1:0] a_cls;
    fclass_t [NUM_LANES-1:0] b_cls;
    logic [NUM_LANES-1:0]    a_less;
    logic [NUM_LANES-1:0]    equal;

    stage0_t s0_in;
    stage0_t s0;
    logic    s0_valid;

    logic [NUM_LANES-1:0][31:0] lane_res;
    logic [NUM_LANES-1:0]       lane_nv;
    logic                       has_fflags_s0;
    fpu_rsp_t                   rsp_s0;

    logic stall;

    assign stall     = rsp_valid & ~rsp_ready;
    assign req_ready = ~stall;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_in
        logic [EXP_BITS+MAN_BITS-1:0] mag_a;
        logic [EXP_BITS+MAN_BITS-1:0] mag_b;
        logic                         sign_a;
        logic                         sign_b;

        fpu_class u_class_a (
            .exp (req.a[i].f.exp),
            .man (req.a[i].f.man),
            .cls (a_cls[i])
        );

        fpu_class u_class_b (
            .exp (req.b[i].f.exp),
            .man (req.b[i].f.man),
            .cls (b_cls[i])
        );

        assign sign_a = req.a[i].f.sign;
        assign sign_b = req.b[i].f.sign;
        assign mag_a  = {req.a[i].f.exp, req.a[i].f.man};
        assign mag_b  = {req.b[i].f.exp, req.b[i].f.man};

        // Sign-magnitude order with -0 below +0
        assign a_less[i] = (sign_a != sign_b) ? sign_a :
                           sign_a ? (mag_a > mag_b) : (mag_a < mag_b);
        assign equal[i]  = (req.a[i].bits == req.b[i].bits) |
                           (a_cls[i].is_zero & b_cls[i].is_zero);
    end

    assign s0_in = '{req: req, a_cls: a_cls, b_cls: b_cls, a_less: a_less, equal: equal};

    pipe_register #(
        .DATAW ($bits(stage0_t))
    ) u_reg0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (~stall),
        .valid_in  (req_valid),
        .valid_out (s0_valid),
        .data_in   (s0_in),
        .data_out  (s0)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_res
        fp32_u       a;
        fp32_u       b;
        fclass_t     ca;
        fclass_t     cb;
        logic        any_nan;
        logic        any_snan;
        logic [31:0] cls_mask;
        fp32_u       sgnj;
        logic [31:0] minmax;
        logic [31:0] res;
        logic        nv;

        assign a        = s0.req.a[i];
        assign b        = s0.req.b[i];
        assign ca       = s0.a_cls[i];
        assign cb       = s0.b_cls[i];
        assign any_nan  = ca.is_nan | cb.is_nan;
        assign any_snan = ca.is_signaling | cb.is_signaling;

        always_comb begin
            cls_mask = '0;
            if (ca.is_nan)
                cls_mask[ca.is_quiet ? CLS_QNAN : CLS_SNAN] = 1'b1;
            else if (ca.is_inf)
                cls_mask[a.f.sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
            else if (ca.is_normal)
                cls_mask[a.f.sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
            else if (ca.is_subnormal)
                cls_mask[a.f.sign ? CLS_NEG_SUBNORM : CLS_POS_SUBNORM] = 1'b1;
            else
                cls_mask[a.f.sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        end

        always_comb begin
            sgnj = a;
            case (s0.req.frm)
                FRM_SGNJN: sgnj.f.sign = ~b.f.sign;
                FRM_SGNJX: sgnj.f.sign = a.f.sign ^ b.f.sign;
                default:   sgnj.f.sign = b.f.sign;
            endcase
        end

        always_comb begin
            if (ca.is_nan && cb.is_nan)
                minmax = CANON_NAN;
            else if (ca.is_nan)
                minmax = b.bits;
            else if (cb.is_nan)
                minmax = a.bits;
            else if (s0.req.frm == FRM_MIN)
                minmax = s0.a_less[i] ? a.bits : b.bits;
            else
                minmax = s0.a_less[i] ? b.bits : a.bits;
        end

        always_comb begin
            res = '0;
            nv  = 1'b0;
            case (s0.req.op)
                OP_CLASS: res = cls_mask;
                OP_CMP: begin
                    case (s0.req.frm)
                        FRM_LE: begin
                            res[0] = (s0.a_less[i] | s0.equal[i]) & ~any_nan;
                            nv     = any_nan;
                        end
                        FRM_LT: begin
                            res[0] = s0.a_less[i] & ~s0.equal[i] & ~any_nan;
                            nv     = any_nan;
                        end
                        FRM_EQ: begin
                            res[0] = s0.equal[i] & ~any_nan;
                            nv     = any_snan;    // Quiet compare
                        end
                        default: ;
                    endcase
                end
                OP_MISC: begin
                    case (s0.req.frm)
                        FRM_SGNJ, FRM_SGNJN, FRM_SGNJX: res = sgnj.bits;
                        FRM_MIN, FRM_MAX: begin
                            res = minmax;
                            nv  = any_snan;
                        end
                        default: res = a.bits;   // Move
                    endcase
                end
                default: ;
            endcase
        end

        assign lane_res[i] = res;
        assign lane_nv[i]  = nv;
    end

    assign has_fflags_s0 = (s0.req.op == OP_CMP) ||
                           ((s0.req.op == OP_MISC) &&
                            (s0.req.frm == FRM_MIN || s0.req.frm == FRM_MAX));

    assign rsp_s0 = '{tag: s0.req.tag, result: lane_res, has_fflags: has_fflags_s0,
                      nv: lane_nv};

    pipe_register #(
        .DATAW ($bits(fpu_rsp_t))
    ) u_reg1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (~stall),
        .valid_in  (s0_valid),
        .valid_out (rsp_valid),
        .data_in   (rsp_s0),
        .data_out  (rsp)
    );

    rsp_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rsp_valid));

endmodule

`default_nettype wire

// File: logic/fpu_misc_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_misc_unit
    import fpu_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  wire      req_valid,
    output logic     req_ready,
    input  fpu_req_t req,
    output logic     rsp_valid,
    input  wire      rsp_ready,
    output fpu_rsp_t rsp
);

    // Non-computational ops in two pipeline stages
    fpu_ncomp u_ncomp (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// File: test/fpu_ref.svh
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

function automatic logic nan_word(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
endfunction

function automatic logic snan_word(input logic [31:0] x);
    return nan_word(x) && !x[22];
endfunction

// Unsigned key in value order with -0 just below +0
function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? 32'h7fff_ffff - {1'b0, x[30:0]} : 32'h8000_0000 + {1'b0, x[30:0]};
endfunction

function automatic logic [31:0] class_mask(input logic [31:0] x);
    logic [4:0] pos;
    if (nan_word(x))
        pos = x[22] ? 5'd9 : 5'd8;
    else if (x[30:23] == 8'hff)
        pos = x[31] ? 5'd0 : 5'd7;
    else if (x[30:23] != 8'h00)
        pos = x[31] ? 5'd1 : 5'd6;
    else if (x[22:0] != 23'd0)
        pos = x[31] ? 5'd2 : 5'd5;
    else
        pos = x[31] ? 5'd3 : 5'd4;
    return 32'd1 << pos;
endfunction

// NV in bit 32 above the result
function automatic logic [32:0] lane_result(input fpu_op_e op, input logic [2:0] frm,
                                            input logic [31:0] a, input logic [31:0] b);
    logic        nan;
    logic        snan;
    logic        eq;
    logic        lt;
    logic [31:0] pick;
    nan  = nan_word(a) || nan_word(b);
    snan = snan_word(a) || snan_word(b);
    eq   = (a == b) || (a[30:0] == 31'd0 && b[30:0] == 31'd0);
    lt   = order_key(a) < order_key(b);
    pick = (lt == (frm == FRM_MIN)) ? a : b;
    if (nan_word(a) && nan_word(b))
        pick = 32'h7fc0_0000;
    else if (nan)
        pick = nan_word(a) ? b : a;   // The non-NaN side wins
    case (op)
        OP_CLASS: return {1'b0, class_mask(a)};
        OP_CMP: begin
            case (frm)
                FRM_LE:  return {nan, 31'd0, (lt || eq) && !nan};
                FRM_LT:  return {nan, 31'd0, lt && !eq && !nan};
                FRM_EQ:  return {snan, 31'd0, eq && !nan};
                default: return 33'd0;
            endcase
        end
        OP_MISC: begin
            case (frm)
                FRM_SGNJ:         return {1'b0, b[31], a[30:0]};
                FRM_SGNJN:        return {1'b0, ~b[31], a[30:0]};
                FRM_SGNJX:        return {1'b0, a[31] ^ b[31], a[30:0]};
                FRM_MIN, FRM_MAX: return {snan, pick};
                default:          return {1'b0, a};   // Move
            endcase
        end
        default: return 33'd0;
    endcase
endfunction

function automatic fpu_rsp_t expected_rsp(input fpu_req_t rq);
    fpu_rsp_t    e;
    logic [32:0] lane;
    e = '0;
    e.tag = rq.tag;
    case (rq.op)
        OP_CMP:  e.has_fflags = 1'b1;
        OP_MISC: e.has_fflags = (rq.frm == FRM_MIN) || (rq.frm == FRM_MAX);
        default: e.has_fflags = 1'b0;
    endcase
    for (int l = 0; l < NUM_LANES; l++) begin
        lane        = lane_result(rq.op, rq.frm, rq.a[l].bits, rq.b[l].bits);
        e.result[l] = lane[31:0];
        e.nv[l]     = lane[32];
    end
    return e;
endfunction

`endif

// File: test/tb_fpu_misc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_misc
    import fpu_pkg::*;
();

    `include "fpu_ref.svh"

    localparam int NUM_DIRECTED = 12 * 256;   // Every op kind on every table pair
    localparam int NUM_RANDOM   = 600;
    localparam int NUM_LAT      = 8;
    localparam int NUM_TOTAL    = NUM_DIRECTED + NUM_RANDOM + NUM_LAT;
    localparam int CYCLE_LIMIT  = 4 * NUM_TOTAL + 100;

    typedef struct packed {
        fpu_op_e    op;
        logic [2:0] frm;
        fpu_rsp_t   rsp;
    } expect_t;

    logic     clk       = 1'b0;
    logic     rst_n     = 1'b0;
    logic     req_valid = 1'b0;
    logic     req_ready;
    fpu_req_t req       = '0;
    logic     rsp_valid;
    logic     rsp_ready = 1'b0;
    fpu_rsp_t rsp;

    expect_t     exp_q[$];
    expect_t     exp_head  = '0;
    logic        pending   = 1'b0;
    logic        lat_mode  = 1'b0;
    logic [31:0] rnd_state = 32'h46ad7d1c;
    int          sent      = 0;
    int          rsp_cnt   = 0;
    int          cycles    = 0;

    // Zeros, subnormals, normals, infinities, quiet and signaling NaNs
    logic [31:0] special [16] = '{
        32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h807f_ffff,
        32'h0080_0000, 32'hbf80_0000, 32'h3f80_0000, 32'h3f80_0001,
        32'hc049_0fdb, 32'h7f7f_ffff, 32'h7f80_0000, 32'hff80_0000,
        32'h7fc0_0000, 32'hffc0_0001, 32'h7f80_0001, 32'hff9f_ffff
    };

    fpu_misc_unit UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic roll(output logic [31:0] r);
        rnd_state = xorshift32(rnd_state);
        r = rnd_state;
    endtask

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic refresh_head();
        pending  = (exp_q.size() != 0);
        exp_head = pending ? exp_q[0] : '0;
    endtask

    task automatic build_req(input int n);
        logic [31:0] r;
        logic [3:0]  kind;
        roll(r);
        kind = (n < NUM_DIRECTED) ? n[11:8] : 4'(r % 32'd12);
        req.tag = n[3:0];
        if (kind == 4'd0) begin
            req.op  = OP_CLASS;
            req.frm = r[10:8];
        end else if (kind < 4'd4) begin
            req.op  = OP_CMP;
            req.frm = 3'(kind - 4'd1);
        end else begin
            req.op  = OP_MISC;
            req.frm = 3'(kind - 4'd4);   // 5 to 7 all move
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (n < NUM_DIRECTED) begin
                // Odd lanes see the pair swapped
                req.a[l].bits = special[l[0] ? n[3:0] : n[7:4]];
                req.b[l].bits = special[l[0] ? n[7:4] : n[3:0]];
            end else begin
                roll(r);
                req.a[l].bits = r[0] ? special[r[4:1]] : r;
                roll(r);
                req.b[l].bits = r[0] ? special[r[4:1]] : r;
            end
        end
    endtask

    // One clock with accept decided once inputs have settled
    task automatic run_cycle(input logic ready);
        logic take;
        rsp_ready = ready;
        #2;
        take = req_valid && req_ready;
        if (take) begin
            exp_q.push_back(expect_t'{op: req.op, frm: req.frm, rsp: expected_rsp(req)});
            refresh_head();
        end
        @(posedge clk);
        #1;
        if (take) begin
            req_valid = 1'b0;
            sent++;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (rst_n && rsp_valid && rsp_ready && pending) begin
            void'(exp_q.pop_front());
            rsp_cnt++;
            refresh_head();
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d responses missing", cycles, exp_q.size());
            fail_run();
        end
    end

    rsp_matches: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready && pending |-> rsp == exp_head.rsp)
    else begin
        $display("error op %0d frm %0d: expected %h actual %h",
                 $sampled(exp_head.op), $sampled(exp_head.frm),
                 $sampled(exp_head.rsp), $sampled(rsp));
        fail_run();
    end

    rsp_requested: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> pending)
    else begin
        $display("A response came out with no request outstanding");
        fail_run();
    end

    latency_two: assert property (@(posedge clk) disable iff (!rst_n)
        lat_mode && rsp_valid |-> $past(req_valid && req_ready, 2))
    else begin
        $display("Response did not arrive exactly two cycles after its request");
        fail_run();
    end

    reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !rsp_valid && req_ready)
    else begin
        $display("Handshake outputs not idle when reset was released");
        fail_run();
    end

    initial begin
        logic [31:0] r;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (sent < NUM_DIRECTED + NUM_RANDOM) begin
            roll(r);
            if (!req_valid && r[1:0] != 2'd0) begin
                build_req(sent);
                req_valid = 1'b1;
            end
            run_cycle(r[3:2] != 2'd0);   // Random back-pressure
        end
        while (pending) begin
            roll(r);
            run_cycle(r[2]);
        end
        lat_mode = 1'b1;   // Isolated requests without stalls
        repeat (NUM_LAT) begin
            build_req(sent);
            req_valid = 1'b1;
            while (req_valid)
                run_cycle(1'b1);
            repeat (3) run_cycle(1'b1);
        end
        while (pending)
            run_cycle(1'b1);
        if (rsp_cnt == sent && sent == NUM_TOTAL) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Got %0d responses for %0d requests", rsp_cnt, sent);
            fail_run();
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+test
logic/fpu_pkg.sv
logic/fpu_class.sv
logic/pipe_register.sv
logic/fpu_ncomp.sv
logic/fpu_misc_unit.sv
test/tb_fpu_misc.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f src.f --top-module tb_fpu_misc &&
./obj_dir/Vtb_fpu_misc | tee /dev/stderr | grep -qF "All tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
